// File: hdl/arb_pkg.sv
/*
 * arbiter package
 * client count, id width and the payload and grant types shared by all stages
 */
package arb_pkg;

   // number of requesting clients
   localparam int num_clients = 5;

   // ceiling log2 that never returns zero
   // a one-entry vector still needs a one-bit address
   function automatic int safe_clog2(input int w);
      return (w > 1) ? $clog2(w) : 1;
   endfunction

   // next power of two at or above w
   function automatic int pow2_ceil(input int w);
      return 1 << $clog2(w);
   endfunction

   // width of a client id
   localparam int client_id_w = safe_clog2(num_clients);

   // request payload, 20 bits
   typedef struct packed
   {
      logic [3:0]  tag;
      logic [15:0] data;
   } payload_t;

   // arbitration result
   // one_hot is zero when v is low
   typedef struct packed
   {
      logic [num_clients-1:0] one_hot;
      logic [client_id_w-1:0] id;
      logic                   v;
   } grant_t;

endpackage

// File: hdl/encode_one_hot.sv
/*
 * one-hot to binary encoder
 * recursive OR tree, returns the set bit position and an any-bit-set flag
 */
module encode_one_hot
   import arb_pkg::*;
#(
   parameter int width_p = 8
)
(
   input  logic [width_p-1:0]             i,
   output logic [safe_clog2(width_p)-1:0] addr_o,
   output logic                           v_o
);

   // examples for width 4, low to high
   //   0001 -> 0, v=1
   //   0100 -> 2, v=1
   //   0000 -> 0, v=0
   // more than one bit set gives an undefined address

   if (width_p == 1)
   begin : base
      assign v_o    = i[0];
      // only one position, address is always zero
      assign addr_o = 1'b0;
   end
   else if (width_p == 2)
   begin : leaf
      assign v_o    = |i;
      assign addr_o = i[1];
   end
   else if (width_p != pow2_ceil(width_p))
   begin : unaligned
      // pad once at the top so every level below splits evenly
      // clog2 of the padded width equals clog2 of width_p
      logic [pow2_ceil(width_p)-1:0]  padded;
      logic [safe_clog2(width_p)-1:0] aligned_addr;

      // zeros go above the real inputs
      assign padded = {{(pow2_ceil(width_p) - width_p){1'b0}}, i};

      encode_one_hot #(.width_p(pow2_ceil(width_p))) align
      (
         .i      (padded),
         .addr_o (aligned_addr),
         .v_o    (v_o)
      );

      assign addr_o = aligned_addr;
   end
   else
   begin : aligned
      // per-half sub-addresses and hit flags
      logic [1:0][safe_clog2(width_p/2)-1:0] addrs;
      logic [1:0]                            vs;

      // lower half
      encode_one_hot #(.width_p(width_p/2)) lo
      (
         .i      (i[0 +: width_p/2]),
         .addr_o (addrs[0]),
         .v_o    (vs[0])
      );

      // upper half
      encode_one_hot #(.width_p(width_p/2)) hi
      (
         .i      (i[width_p/2 +: width_p/2]),
         .addr_o (addrs[1]),
         .v_o    (vs[1])
      );

      assign v_o    = |vs;
      // the idle half contributes zeros, so OR merges the two addresses
      // upper half hit becomes the msb
      assign addr_o = {vs[1], addrs[0] | addrs[1]};
   end

endmodule

// File: hdl/req_capture.sv
/*
 * request capture stage
 * holds one pending flag and one payload per client until granted
 */
module req_capture
   import arb_pkg::*;
#(
   parameter type payload_type = payload_t
)
(
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic [num_clients-1:0]              req_v_i,
   input  payload_type [num_clients-1:0]       req_payload_i,
   input  grant_t                              grant_i,
   output logic [num_clients-1:0]              pend_v_o,
   output payload_type [num_clients-1:0]       pend_payload_o
);

   logic [num_clients-1:0]        pend_v_q;
   payload_type [num_clients-1:0] pend_payload_q;
   // clients released this cycle
   logic [num_clients-1:0]        granted;
   // pulses that get stored
   logic [num_clients-1:0]        accept;

   assign granted = grant_i.v ? grant_i.one_hot : '0;

   // idle slot, or slot freed by the grant in this same cycle
   // a pulse on a busy slot is dropped and the old payload stays
   assign accept = req_v_i & (~pend_v_q | granted);

   // pending flags
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         pend_v_q <= '0;
      end
      else
      begin
         // clear on grant, set on accepted pulse
         // a grant and a pulse together leave the flag set
         pend_v_q <= (pend_v_q & ~granted) | accept;
      end
   end

   // payload slots, only written with the flag
   always_ff @(posedge clk_i)
   begin
      for (int c = 0; c < num_clients; c++)
      begin
         if (accept[c])
         begin
            pend_payload_q[c] <= req_payload_i[c];
         end
      end
   end

   assign pend_v_o       = pend_v_q;
   assign pend_payload_o = pend_payload_q;

   // a grant with no new pulse must free the slot on the next cycle
   for (genvar g = 0; g < num_clients; g++)
   begin : chk
      a_grant_clears: assert property (
         @(posedge clk_i) disable iff (!rst_n_i)
         (granted[g] && !req_v_i[g]) |=> !pend_v_q[g]
      ) else $error("req_capture: client %0d still pending after grant", g);
   end

endmodule

// File: hdl/rr_arbiter.sv
/*
 * round-robin arbiter
 * grants one pending client per cycle, starting after the last one served
 */
module rr_arbiter
   import arb_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic [num_clients-1:0] pend_v_i,
   output grant_t                 grant_o
);

   // id of the last granted client
   logic [client_id_w-1:0]     ptr_q;
   // search start, pointer plus one with wrap
   logic [client_id_w-1:0]     start_id;
   // pending vector rotated so the start client sits at bit 0
   logic [2*num_clients-1:0]   pend_dbl;
   logic [num_clients-1:0]     pend_rot;
   // lowest set bit of the rotated vector
   logic [num_clients-1:0]     first_rot;
   // rotated back into client order
   logic [2*num_clients-1:0]   first_dbl;
   logic [num_clients-1:0]     one_hot;
   logic [client_id_w-1:0]     grant_id;
   logic                       grant_v;

   always_comb
   begin
      if (ptr_q == client_id_w'(num_clients - 1))
      begin
         start_id = '0;
      end
      else
      begin
         start_id = ptr_q + 1'b1;
      end
   end

   // rotate right by start_id through a doubled copy
   assign pend_dbl  = {pend_v_i, pend_v_i} >> start_id;
   assign pend_rot  = pend_dbl[num_clients-1:0];

   // isolate the lowest set bit, two's complement trick
   assign first_rot = pend_rot & (~pend_rot + 1'b1);

   // rotate left by the same amount, upper copy holds the result
   assign first_dbl = {first_rot, first_rot} << start_id;
   assign one_hot   = first_dbl[2*num_clients-1:num_clients];

   // id of the winner, valid doubles as any-pending
   encode_one_hot #(.width_p(num_clients)) enc
   (
      .i      (one_hot),
      .addr_o (grant_id),
      .v_o    (grant_v)
   );

   assign grant_o.one_hot = one_hot;
   assign grant_o.id      = grant_id;
   assign grant_o.v       = grant_v;

   // pointer only moves on a real grant
   // reset to the last client so client 0 wins first
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ptr_q <= client_id_w'(num_clients - 1);
      end
      else if (grant_v)
      begin
         ptr_q <= grant_id;
      end
   end

   // encoder input must be zero or one-hot
   a_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(one_hot)
   ) else $error("rr_arbiter: grant not one-hot %b", one_hot);

   // nothing pending means no grant, anything pending means a grant
   a_valid: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      grant_v == (|pend_v_i)
   ) else $error("rr_arbiter: grant valid disagrees with pending");

   a_granted_pending: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (one_hot & ~pend_v_i) == '0
   ) else $error("rr_arbiter: grant to a client with no request");

endmodule

// File: hdl/grant_output.sv
/*
 * grant output stage
 * picks the granted payload and registers the strobe, id and payload
 */
module grant_output
   import arb_pkg::*;
#(
   parameter type payload_type = payload_t
)
(
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  grant_t                        grant_i,
   input  payload_type [num_clients-1:0] pend_payload_i,
   output logic                          out_v_o,
   output logic [client_id_w-1:0]        out_id_o,
   output payload_type                   out_payload_o
);

   payload_type            sel_payload;
   logic                   out_v_q;
   logic [client_id_w-1:0] out_id_q;
   payload_type            out_payload_q;

   // payload mux by grant id
   // ids past the last client select nothing
   always_comb
   begin
      sel_payload = '0;
      for (int c = 0; c < num_clients; c++)
      begin
         if (grant_i.id == client_id_w'(c))
         begin
            sel_payload = pend_payload_i[c];
         end
      end
   end

   // strobe every cycle, id and payload only on a grant
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         out_v_q       <= 1'b0;
         out_id_q      <= '0;
         out_payload_q <= '0;
      end
      else
      begin
         out_v_q <= grant_i.v;
         if (grant_i.v)
         begin
            out_id_q      <= grant_i.id;
            out_payload_q <= sel_payload;
         end
      end
   end

   assign out_v_o       = out_v_q;
   assign out_id_o      = out_id_q;
   assign out_payload_o = out_payload_q;

   // a strobed id names a real client
   a_id_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      out_v_o |-> (out_id_o < client_id_w'(num_clients))
   ) else $error("grant_output: id %0d out of range", out_id_o);

endmodule

// File: hdl/arb_top.sv
/*
 * round-robin request arbiter top
 * capture, arbitrate and register the grant for five clients
 */
module arb_top
   import arb_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [num_clients-1:0]     req_v_i,
   input  payload_t [num_clients-1:0] req_payload_i,
   output logic                       out_v_o,
   output logic [client_id_w-1:0]     out_id_o,
   output payload_t                   out_payload_o
);

   // pending state from the capture stage
   logic [num_clients-1:0]     pend_v;
   payload_t [num_clients-1:0] pend_payload;
   // this cycle's winner
   grant_t                     grant;

   // decode, hold requests until served
   req_capture #(.payload_type(payload_t)) u_capture
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .req_v_i        (req_v_i),
      .req_payload_i  (req_payload_i),
      .grant_i        (grant),
      .pend_v_o       (pend_v),
      .pend_payload_o (pend_payload)
   );

   // execute, combinational pick plus pointer
   rr_arbiter u_arbiter
   (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .pend_v_i (pend_v),
      .grant_o  (grant)
   );

   // result, registered one cycle after the grant
   grant_output #(.payload_type(payload_t)) u_output
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .grant_i        (grant),
      .pend_payload_i (pend_payload),
      .out_v_o        (out_v_o),
      .out_id_o       (out_id_o),
      .out_payload_o  (out_payload_o)
   );

endmodule

// File: bench/tb_arb_top.sv
/*
 * testbench for the round-robin request arbiter
 * directed tests and random traffic, checked against a reference model
 */
module tb_arb_top
   import arb_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // cycle budget, a fixed allowance per directed test plus the random run
   localparam int rand_cycles    = 300;
   localparam int test_allowance = 40;
   localparam int budget_cycles  = rand_cycles + 6 * test_allowance + 100;
   localparam int strobe_timeout = 4 * num_clients;

   logic                       clk_i;
   logic                       rst_n_i;
   logic [num_clients-1:0]     req_v_i;
   payload_t [num_clients-1:0] req_payload_i;
   logic                       out_v_o;
   logic [client_id_w-1:0]     out_id_o;
   payload_t                   out_payload_o;

   // reference model state
   logic [num_clients-1:0]     m_pend;
   payload_t [num_clients-1:0] m_payload;
   int                         m_ptr;
   bit                         m_out_v;
   int                         m_out_id;
   payload_t                   m_out_payload;
   bit                         model_ready  = 1'b0;
   int                         accept_count = 0;
   int                         strobe_count = 0;
   integer                     seed         = 32'h2c6e_fb5a;

   arb_top uut
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_v_i       (req_v_i),
      .req_payload_i (req_payload_i),
      .out_v_o       (out_v_o),
      .out_id_o      (out_id_o),
      .out_payload_o (out_payload_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial
   begin
      repeat (budget_cycles) @(posedge clk_i);
      $display("** FAIL **");
      $fatal(1, "watchdog: tests did not finish within %0d cycles", budget_cycles);
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
         $display("** FAIL **");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   // one edge of the model, inputs are the values sampled at this edge
   task automatic model_step();
      int g;
      int idx;
      if (!rst_n_i)
      begin
         m_pend        = '0;
         m_ptr         = num_clients - 1;
         m_out_v       = 1'b0;
         m_out_id      = 0;
         m_out_payload = '0;
      end
      else
      begin
         // search from pointer+1 with wrap
         g = -1;
         for (int k = 1; k <= num_clients; k++)
         begin
            idx = (m_ptr + k) % num_clients;
            if (g < 0 && m_pend[idx])
            begin
               g = idx;
            end
         end
         m_out_v = (g >= 0);
         if (g >= 0)
         begin
            m_out_id      = g;
            m_out_payload = m_payload[g];
            m_pend[g]     = 1'b0;
            m_ptr         = g;
         end
         // idle or just granted slots take the new pulse
         for (int c = 0; c < num_clients; c++)
         begin
            if (req_v_i[c] && !m_pend[c])
            begin
               m_pend[c]    = 1'b1;
               m_payload[c] = req_payload_i[c];
               accept_count++;
            end
         end
      end
   endtask

   always @(posedge clk_i)
   begin
      model_step();
      model_ready = 1'b1;
   end

   // outputs compared mid-cycle, away from the edge
   always @(negedge clk_i)
   begin
      if (model_ready)
      begin
         check_value("out_v_o", 32'(out_v_o), 32'(m_out_v));
         check_value("out_id_o", 32'(out_id_o), 32'(m_out_id));
         check_value("out_payload_o", 32'(out_payload_o), 32'(m_out_payload));
         if (out_v_o)
         begin
            strobe_count++;
         end
      end
   end

   task automatic drive_cycle(input logic [num_clients-1:0] mask,
                              input payload_t [num_clients-1:0] pl);
      @(posedge clk_i);
      req_v_i       <= mask;
      req_payload_i <= pl;
   endtask

   // returns on the edge that samples the pulse
   task automatic drive_pulse(input logic [num_clients-1:0] mask,
                              input payload_t [num_clients-1:0] pl);
      drive_cycle(mask, pl);
      drive_cycle('0, pl);
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      rst_n_i <= 1'b0;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
   endtask

   // next_cycle set means the strobe must follow the previous one directly
   task automatic expect_strobe(input int id, input payload_t pl, input bit next_cycle);
      int waited;
      waited = 0;
      @(negedge clk_i);
      if (next_cycle)
      begin
         check_value("back-to-back strobe", 32'(out_v_o), 32'd1);
      end
      else
      begin
         while (!out_v_o)
         begin
            waited++;
            if (waited > strobe_timeout)
            begin
               $display("** FAIL **");
               $fatal(1, "no output strobe within %0d cycles", strobe_timeout);
            end
            @(negedge clk_i);
         end
      end
      check_value("strobe id", 32'(out_id_o), 32'(id));
      check_value("strobe payload", 32'(out_payload_o), 32'(pl));
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk_i);
         check_value("unexpected strobe", 32'(out_v_o), 32'd0);
      end
   endtask

   task automatic test_single();
      payload_t [num_clients-1:0] pl;
      pl    = '0;
      pl[3] = {4'h3, 16'hbeef};
      @(negedge clk_i);
      check_value("out_v_o after reset", 32'(out_v_o), 32'd0);
      drive_pulse(5'b01000, pl);
      @(negedge clk_i);
      check_value("out_v_o one cycle after request", 32'(out_v_o), 32'd0);
      @(negedge clk_i);
      check_value("out_v_o two cycles after request", 32'(out_v_o), 32'd1);
      check_value("single id", 32'(out_id_o), 32'd3);
      check_value("single payload", 32'(out_payload_o), 32'(pl[3]));
      expect_quiet(3);
   endtask

   // fresh reset so the pointer starts before client 0
   task automatic test_all_clients();
      payload_t [num_clients-1:0] pl;
      apply_reset();
      for (int c = 0; c < num_clients; c++)
      begin
         pl[c] = {4'(c), 16'h1100 + 16'(c)};
      end
      drive_pulse('1, pl);
      for (int c = 0; c < num_clients; c++)
      begin
         expect_strobe(c, pl[c], c != 0);
      end
      expect_quiet(2);
   endtask

   task automatic test_rotation();
      payload_t [num_clients-1:0] pl;
      pl    = '0;
      pl[2] = {4'h2, 16'h2222};
      drive_pulse(5'b00100, pl);
      expect_strobe(2, pl[2], 1'b0);
      // pointer at 2, so 3 wins over 1
      pl[1] = {4'h1, 16'h1111};
      pl[3] = {4'h3, 16'h3333};
      drive_pulse(5'b01010, pl);
      expect_strobe(3, pl[3], 1'b0);
      expect_strobe(1, pl[1], 1'b1);
      expect_quiet(2);
   endtask

   task automatic test_ignored();
      payload_t [num_clients-1:0] first;
      payload_t [num_clients-1:0] second;
      first    = '0;
      first[2] = {4'h2, 16'ha002};
      first[3] = {4'h3, 16'ha003};
      first[4] = {4'h4, 16'ha004};
      second    = first;
      second[4] = {4'h4, 16'hb004};
      // client 4 pulses again while 2 is being served
      drive_cycle(5'b11100, first);
      drive_cycle(5'b10000, second);
      drive_cycle('0, second);
      expect_strobe(2, first[2], 1'b0);
      expect_strobe(3, first[3], 1'b1);
      expect_strobe(4, first[4], 1'b1);
      expect_quiet(num_clients + 2);
   endtask

   task automatic test_regrant();
      payload_t [num_clients-1:0] old_pl;
      payload_t [num_clients-1:0] new_pl;
      old_pl    = '0;
      old_pl[1] = {4'h1, 16'hc001};
      new_pl    = old_pl;
      new_pl[1] = {4'h9, 16'hd001};
      // second pulse lands in the grant cycle of the first
      drive_cycle(5'b00010, old_pl);
      drive_cycle(5'b00010, new_pl);
      drive_cycle('0, new_pl);
      expect_strobe(1, old_pl[1], 1'b0);
      expect_strobe(1, new_pl[1], 1'b1);
      expect_quiet(3);
   endtask

   task automatic test_random();
      logic [num_clients-1:0]     mask;
      payload_t [num_clients-1:0] pl;
      logic [31:0]                rnd;
      pl = '0;
      for (int n = 0; n < rand_cycles; n++)
      begin
         // two draws anded, about one pulse in four per client
         mask = num_clients'($random(seed) & $random(seed));
         for (int c = 0; c < num_clients; c++)
         begin
            rnd   = $random(seed);
            pl[c] = rnd[19:0];
         end
         drive_cycle(mask, pl);
      end
      drive_cycle('0, pl);
      // drain, at most one entry per client left
      repeat (num_clients + 3) @(negedge clk_i);
      @(posedge clk_i);
      check_value("strobes against accepted requests", 32'(strobe_count),
                  32'(accept_count));
      check_value("entries left pending", 32'(uut.pend_v), 32'd0);
   endtask

   initial
   begin
      rst_n_i       = 1'b0;
      req_v_i       = '0;
      req_payload_i = '0;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      test_single();
      test_all_clients();
      test_rotation();
      test_ignored();
      test_regrant();
      test_random();
      $display("** PASS **");
      $finish;
   end

endmodule

// File: build.f
hdl/arb_pkg.sv
hdl/encode_one_hot.sv
hdl/req_capture.sv
hdl/rr_arbiter.sv
hdl/grant_output.sv
hdl/arb_top.sv
bench/tb_arb_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the arbiter testbench with verilator
# exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_arb_top \
   -f build.f \
   -o sim_tb_arb_top
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed"
   exit $status
fi

./obj_dir/sim_tb_arb_top
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit $status
